//--- grid_settings.svh
`ifndef GRID_SETTINGS_SVH
`define GRID_SETTINGS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Compute slot sizing
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`define GRID_XLEN        32    // Datapath width, RV32.

`define GRID_FIFO_DEPTH  8     // Entries per operand queue, power of two.

`define GRID_LSQ_DEPTH   4     // Requests held in front of the memory.

// Word count of the data memory.
// The word index comes from address bits [7:2].
`define GRID_MEM_WORDS   64

`endif

//--- grid_pkg.sv
`default_nettype none

`include "grid_settings.svh"

package grid_pkg;

    // Operation loaded into the slot, held while idle.
    typedef enum logic [2:0] {
        OP_ADD   = 3'd0,
        OP_SUB   = 3'd1,
        OP_XOR   = 3'd2,
        OP_PASS  = 3'd3,    // Forwards input 2.
        OP_LOAD  = 3'd4,
        OP_STORE = 3'd5
    } slot_op_e;

    // RISC-V load/store size and sign encoding.
    typedef enum logic [2:0] {
        FN3_B  = 3'b000,
        FN3_H  = 3'b001,
        FN3_W  = 3'b010,
        FN3_BU = 3'b100,
        FN3_HU = 3'b101
    } mem_fn3_e;

    typedef struct packed {
        logic [`GRID_XLEN-1:0] addr;
        logic [`GRID_XLEN-1:0] data;    // Store data.
        mem_fn3_e              fn3;
        logic                  load;
        logic                  store;
    } lsq_req_t;

    typedef struct packed {
        logic [`GRID_XLEN-1:0] data;    // Extended load result.
    } lsq_resp_t;

endpackage

`default_nettype wire

//--- operand_fifo.sv
`default_nettype none

`include "grid_settings.svh"

module operand_fifo (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  push,
    input  logic                  pop,
    input  logic [`GRID_XLEN-1:0] data_in,
    output logic [`GRID_XLEN-1:0] data_out,
    output logic                  populated
);

    localparam int DEPTH = `GRID_FIFO_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);

    logic [`GRID_XLEN-1:0] buffer [DEPTH];
    logic [PTR_W-1:0]      rd_ptr;
    logic [PTR_W-1:0]      wr_ptr;
    logic [PTR_W:0]        count;
    logic                  full;
    logic                  do_push;
    logic                  do_pop;

    assign full      = (count == (PTR_W+1)'(DEPTH));
    assign populated = (count != '0);
    assign do_push   = push && !full;      // A word arriving when full is lost.
    assign do_pop    = pop && populated;
    assign data_out  = buffer[rd_ptr];     // Head stays visible until popped.

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Pointers and occupancy
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (reset) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push)
                wr_ptr <= wr_ptr + PTR_W'(1);    // Wraps at the power-of-two depth.
            if (do_pop)
                rd_ptr <= rd_ptr + PTR_W'(1);
            case ({do_push, do_pop})
                2'b10:   count <= count + (PTR_W+1)'(1);
                2'b01:   count <= count - (PTR_W+1)'(1);
                default: count <= count;         // Idle, or push and pop together.
            endcase
        end
    end

    // Storage
    always_ff @(posedge clk) begin
        if (do_push)
            buffer[wr_ptr] <= data_in;
    end

endmodule

`default_nettype wire

//--- slot_op_unit.sv
`default_nettype none

`include "grid_settings.svh"

module slot_op_unit
    import grid_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,

    input  slot_op_e              op,
    input  mem_fn3_e              fn3,

    // Operand queue heads
    input  logic [`GRID_XLEN-1:0] data_in1,
    input  logic [`GRID_XLEN-1:0] data_in2,
    input  logic                  data_valid_in1,
    input  logic                  data_valid_in2,
    output logic                  data_in_ack1,
    output logic                  data_in_ack2,
    output logic                  uses_data_in1,
    output logic                  uses_data_in2,

    output logic [`GRID_XLEN-1:0] data_out,
    output logic                  data_valid_out,

    // LSQ port
    output lsq_req_t              lsq_req,
    output logic                  new_request,
    input  logic                  lsq_full,
    input  lsq_resp_t             load_resp,
    input  logic                  load_complete
);

    logic                  is_mem_op;
    logic                  operands_ready;
    logic                  fire;
    logic                  alu_fire;
    logic [`GRID_XLEN-1:0] alu_result;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Opcode decode
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        uses_data_in1 = (op != OP_PASS);    // PASS reads input 2 only.
        uses_data_in2 = (op != OP_LOAD);    // Loads need only the address.
        is_mem_op     = (op == OP_LOAD) || (op == OP_STORE);
    end

    // Every queue in use must hold a word.
    assign operands_ready = (data_valid_in1 || !uses_data_in1) &&
                            (data_valid_in2 || !uses_data_in2);

    // Memory ops also wait for room in the LSQ.
    assign fire     = operands_ready && !(is_mem_op && lsq_full);
    assign alu_fire = fire && !is_mem_op;

    assign data_in_ack1 = fire && uses_data_in1;    // Pops the queue.
    assign data_in_ack2 = fire && uses_data_in2;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // ALU
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        case (op)
            OP_ADD:  alu_result = data_in1 + data_in2;
            OP_SUB:  alu_result = data_in1 - data_in2;
            OP_XOR:  alu_result = data_in1 ^ data_in2;
            OP_PASS: alu_result = data_in2;
            default: alu_result = data_in2;    // Unused for memory ops.
        endcase
    end

    // Memory request, valid only with new_request.
    always_comb begin
        lsq_req.addr  = data_in1;
        lsq_req.data  = data_in2;
        lsq_req.fn3   = fn3;
        lsq_req.load  = (op == OP_LOAD);
        lsq_req.store = (op == OP_STORE);
    end

    assign new_request = fire && is_mem_op;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Result register
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stores retire silently, so only ALU fires and load returns mark a result.
    always_ff @(posedge clk) begin
        if (reset)
            data_valid_out <= 1'b0;
        else
            data_valid_out <= alu_fire || load_complete;
    end

    always_ff @(posedge clk) begin
        if (load_complete)
            data_out <= load_resp.data;    // Loads come back in issue order.
        else if (alu_fire)
            data_out <= alu_result;
    end

endmodule

`default_nettype wire

//--- grid_pr_slot.sv
`default_nettype none

`include "grid_settings.svh"

module grid_pr_slot
    import grid_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,

    input  slot_op_e              op,
    input  mem_fn3_e              fn3,

    // Operand streams, arriving at their own rates
    input  logic [`GRID_XLEN-1:0] data_in1,
    input  logic [`GRID_XLEN-1:0] data_in2,
    input  logic                  data_valid_in1,
    input  logic                  data_valid_in2,

    output logic [`GRID_XLEN-1:0] data_out,
    output logic                  data_valid_out,

    // LSQ port
    output lsq_req_t              lsq_req,
    output logic                  new_request,
    input  logic                  lsq_full,
    input  lsq_resp_t             load_resp,
    input  logic                  load_complete
);

    logic [`GRID_XLEN-1:0] fifo1_head;
    logic [`GRID_XLEN-1:0] fifo2_head;
    logic                  fifo1_populated;
    logic                  fifo2_populated;
    logic                  ou_data_in_ack1;
    logic                  ou_data_in_ack2;
    logic                  uses_data_in1;
    logic                  uses_data_in2;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Operand queues
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    operand_fifo input1_fifo (
        .clk,
        .reset,
        .push      (data_valid_in1 && uses_data_in1),   // Unused input is ignored.
        .pop       (ou_data_in_ack1),
        .data_in   (data_in1),
        .data_out  (fifo1_head),
        .populated (fifo1_populated)
    );

    operand_fifo input2_fifo (
        .clk,
        .reset,
        .push      (data_valid_in2 && uses_data_in2),
        .pop       (ou_data_in_ack2),
        .data_in   (data_in2),
        .data_out  (fifo2_head),
        .populated (fifo2_populated)
    );

    // Operation unit
    slot_op_unit ou (
        .clk,
        .reset,
        .op,
        .fn3,
        .data_in1       (fifo1_head),
        .data_in2       (fifo2_head),
        .data_valid_in1 (fifo1_populated),
        .data_valid_in2 (fifo2_populated),
        .data_in_ack1   (ou_data_in_ack1),
        .data_in_ack2   (ou_data_in_ack2),
        .uses_data_in1,
        .uses_data_in2,
        .data_out,
        .data_valid_out,
        .lsq_req,
        .new_request,
        .lsq_full,
        .load_resp,
        .load_complete
    );

endmodule

`default_nettype wire

//--- lsq_memory.sv
`default_nettype none

`include "grid_settings.svh"

module lsq_memory
    import grid_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  lsq_req_t  lsq_req,
    input  logic      new_request,
    input  logic      mem_stall,
    output logic      lsq_full,
    output lsq_resp_t load_resp,
    output logic      load_complete
);

    localparam int DEPTH  = `GRID_LSQ_DEPTH;
    localparam int PTR_W  = $clog2(DEPTH);
    localparam int MEM_AW = $clog2(`GRID_MEM_WORDS);
    localparam int LANES  = `GRID_XLEN / 8;

    lsq_req_t              queue [DEPTH];
    logic [PTR_W-1:0]      head;
    logic [PTR_W-1:0]      tail;
    logic [PTR_W:0]        count;
    logic                  accept;
    logic                  retire;
    lsq_req_t              head_req;

    logic [`GRID_XLEN-1:0] memory [`GRID_MEM_WORDS];
    logic [MEM_AW-1:0]     word_idx;
    logic [`GRID_XLEN-1:0] mem_word;
    logic [`GRID_XLEN-1:0] store_data;
    logic [LANES-1:0]      store_be;
    logic [`GRID_XLEN-1:0] load_shifted;
    logic [`GRID_XLEN-1:0] load_value;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Request queue
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign lsq_full = (count == (PTR_W+1)'(DEPTH));
    assign accept   = new_request && !lsq_full;
    assign retire   = !mem_stall && (count != '0);    // One retire per free cycle.
    assign head_req = queue[head];

    always_ff @(posedge clk) begin
        if (reset) begin
            head          <= '0;
            tail          <= '0;
            count         <= '0;
            load_complete <= 1'b0;
        end else begin
            load_complete <= retire && head_req.load;
            if (accept)
                tail <= tail + PTR_W'(1);
            if (retire)
                head <= head + PTR_W'(1);
            case ({accept, retire})
                2'b10:   count <= count + (PTR_W+1)'(1);
                2'b01:   count <= count - (PTR_W+1)'(1);
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept)
            queue[tail] <= lsq_req;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Data memory
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign word_idx = head_req.addr[MEM_AW+1:2];    // Wraps modulo memory size.
    assign mem_word = memory[word_idx];

    // Store lanes, data replicated across the word.
    always_comb begin
        case (head_req.fn3)
            FN3_B, FN3_BU: begin
                store_data = {LANES{head_req.data[7:0]}};
                store_be   = LANES'(1) << head_req.addr[1:0];
            end
            FN3_H, FN3_HU: begin
                store_data = {(LANES/2){head_req.data[15:0]}};
                store_be   = LANES'(2'b11) << {head_req.addr[1], 1'b0};
            end
            default: begin
                store_data = head_req.data;
                store_be   = '1;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (retire && head_req.store) begin
            for (int i = 0; i < LANES; i++) begin
                if (store_be[i])
                    memory[word_idx][i*8 +: 8] <= store_data[i*8 +: 8];
            end
        end
    end

    // Load extraction: bring the addressed lane down, then extend.
    assign load_shifted = mem_word >> {head_req.addr[1:0], 3'b000};

    always_comb begin
        case (head_req.fn3)
            FN3_B:   load_value = {{(`GRID_XLEN-8){load_shifted[7]}}, load_shifted[7:0]};
            FN3_BU:  load_value = {{(`GRID_XLEN-8){1'b0}}, load_shifted[7:0]};
            FN3_H:   load_value = {{(`GRID_XLEN-16){load_shifted[15]}}, load_shifted[15:0]};
            FN3_HU:  load_value = {{(`GRID_XLEN-16){1'b0}}, load_shifted[15:0]};
            default: load_value = mem_word;
        endcase
    end

    always_ff @(posedge clk) begin
        if (retire && head_req.load)
            load_resp.data <= load_value;    // Held until the next load retires.
    end

endmodule

`default_nettype wire

//--- grid_slot_top.sv
`default_nettype none

`include "grid_settings.svh"

module grid_slot_top
    import grid_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,

    input  slot_op_e              op,
    input  mem_fn3_e              fn3,        // Access size for LOAD and STORE.

    input  logic [`GRID_XLEN-1:0] data_in1,
    input  logic [`GRID_XLEN-1:0] data_in2,
    input  logic                  data_valid_in1,
    input  logic                  data_valid_in2,

    input  logic                  mem_stall,  // Holds the memory back.

    output logic [`GRID_XLEN-1:0] data_out,
    output logic                  data_valid_out
);

    // Slot to memory wiring
    lsq_req_t  lsq_req;
    logic      new_request;
    logic      lsq_full;
    lsq_resp_t load_resp;
    logic      load_complete;

    grid_pr_slot grid_pr_slot_inst (
        .clk,
        .reset,
        .op,
        .fn3,
        .data_in1,
        .data_in2,
        .data_valid_in1,
        .data_valid_in2,
        .data_out,
        .data_valid_out,
        .lsq_req,
        .new_request,
        .lsq_full,
        .load_resp,
        .load_complete
    );

    lsq_memory lsq_memory_inst (
        .clk,
        .reset,
        .lsq_req,
        .new_request,
        .mem_stall,
        .lsq_full,
        .load_resp,
        .load_complete
    );

endmodule

`default_nettype wire

//--- tb_clock_gen.sv
`default_nettype none

module tb_clock_gen (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;    // Period of 4.
    end

endmodule

`default_nettype wire

//--- grid_slot_tb.sv
`default_nettype none

`include "grid_settings.svh"

module grid_slot_tb
    import grid_pkg::*;
();

    localparam int NUM_ROWS    = 36;
    localparam int RESET_FIRST = 31;     // Stalled loads that reset flushes.
    localparam int SPAN        = 32;     // Longest drive schedule of one group.
    localparam int DRAIN_LIMIT = 200;

    typedef struct packed {
        slot_op_e              op;
        mem_fn3_e              fn3;
        logic [`GRID_XLEN-1:0] a;        // Operand 1, or the address.
        logic [`GRID_XLEN-1:0] b;        // Operand 2, or the store data.
        logic signed [3:0]     delay;    // Push of operand 2 relative to operand 1.
        logic                  stall;
        logic                  rnd;      // Replace a and b with random words.
    } row_t;

    logic                  clk;
    logic                  reset;
    slot_op_e              op;
    mem_fn3_e              fn3;
    logic [`GRID_XLEN-1:0] data_in1;
    logic [`GRID_XLEN-1:0] data_in2;
    logic                  data_valid_in1;
    logic                  data_valid_in2;
    logic                  mem_stall;
    logic [`GRID_XLEN-1:0] data_out;
    logic                  data_valid_out;

    row_t                  rows [NUM_ROWS];
    logic [7:0]            mem_bytes [256];    // Byte image of the data memory.
    logic [`GRID_XLEN-1:0] exp_val_q [$];
    int                    exp_cyc_q [$];      // Negative for loads, latency varies.
    slot_op_e              exp_op_q [$];
    logic [`GRID_XLEN-1:0] mon_val;
    int                    mon_cyc;
    slot_op_e              mon_op;
    integer                seed;
    int                    cycle = 0;
    int                    errors = 0;
    int                    nresults = 0;
    logic                  saw_full;

    tb_clock_gen clock_gen_inst (.clk);

    grid_slot_top grid_slot_top_inst (
        .clk,
        .reset,
        .op,
        .fn3,
        .data_in1,
        .data_in2,
        .data_valid_in1,
        .data_valid_in2,
        .mem_stall,
        .data_out,
        .data_valid_out
    );

    always @(posedge clk) cycle <= cycle + 1;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Compare tasks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic check_result(input logic [`GRID_XLEN-1:0] got,
                                input logic [`GRID_XLEN-1:0] exp, input slot_op_e kind);
        if (got !== exp) begin
            errors++;
            $display("ERR %0t: %s result %h, expected %h", $time, kind.name(), got, exp);
        end
    endtask

    task automatic check_latency(input int got, input int exp, input slot_op_e kind);
        if (got != exp) begin
            errors++;
            $display("ERR %0t: %s result in cycle %0d, expected cycle %0d",
                     $time, kind.name(), got, exp);
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("ERR %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Reference model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    function automatic logic [`GRID_XLEN-1:0] alu_expect(input slot_op_e kind,
            input logic [`GRID_XLEN-1:0] a, input logic [`GRID_XLEN-1:0] b);
        case (kind)
            OP_ADD:  alu_expect = a + b;
            OP_SUB:  alu_expect = a - b;
            OP_XOR:  alu_expect = a ^ b;
            default: alu_expect = b;         // PASS forwards operand 2.
        endcase
    endfunction

    // Little-endian lanes, address wraps at 256 bytes.
    function automatic void model_store(input logic [`GRID_XLEN-1:0] addr,
            input logic [`GRID_XLEN-1:0] data, input mem_fn3_e f);
        logic [7:0] ad;
        int         nbytes;
        ad = addr[7:0];
        case (f)
            FN3_B, FN3_BU: nbytes = 1;
            FN3_H, FN3_HU: nbytes = 2;
            default:       nbytes = 4;
        endcase
        for (int i = 0; i < nbytes; i++)
            mem_bytes[ad + 8'(i)] = data[i*8 +: 8];
    endfunction

    function automatic logic [`GRID_XLEN-1:0] model_load(input logic [`GRID_XLEN-1:0] addr,
            input mem_fn3_e f);
        logic [7:0]  ad;
        logic [15:0] half;
        ad   = addr[7:0];
        half = {mem_bytes[ad + 8'd1], mem_bytes[ad]};
        case (f)
            FN3_B:   model_load = {{(`GRID_XLEN-8){mem_bytes[ad][7]}}, mem_bytes[ad]};
            FN3_BU:  model_load = {{(`GRID_XLEN-8){1'b0}}, mem_bytes[ad]};
            FN3_H:   model_load = {{(`GRID_XLEN-16){half[15]}}, half};
            FN3_HU:  model_load = {{(`GRID_XLEN-16){1'b0}}, half};
            default: model_load = {mem_bytes[ad + 8'd3], mem_bytes[ad + 8'd2], half};
        endcase
    endfunction

    task automatic expect_result(input logic [`GRID_XLEN-1:0] val, input int cyc,
                                 input slot_op_e kind);
        exp_val_q.push_back(val);
        exp_cyc_q.push_back(cyc);
        exp_op_q.push_back(kind);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stimulus table
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic fill_table();
        rows[0]  = '{OP_ADD,   FN3_W,  32'd5,         32'd7,         4'sd0,  1'b0, 1'b0};
        rows[1]  = '{OP_ADD,   FN3_W,  32'hffff_ffff, 32'd2,         4'sd0,  1'b0, 1'b0};
        rows[2]  = '{OP_ADD,   FN3_W,  32'h0,         32'h0,         4'sd0,  1'b0, 1'b1};
        rows[3]  = '{OP_ADD,   FN3_W,  32'h0,         32'h0,         4'sd2,  1'b0, 1'b1};
        rows[4]  = '{OP_ADD,   FN3_W,  32'h0,         32'h0,         -4'sd1, 1'b0, 1'b1};
        rows[5]  = '{OP_SUB,   FN3_W,  32'd10,        32'd3,         4'sd0,  1'b0, 1'b0};
        rows[6]  = '{OP_SUB,   FN3_W,  32'd3,         32'd10,        4'sd0,  1'b0, 1'b0};
        rows[7]  = '{OP_SUB,   FN3_W,  32'h0,         32'h0,         4'sd1,  1'b0, 1'b1};
        rows[8]  = '{OP_XOR,   FN3_W,  32'ha5a5_a5a5, 32'hffff_0000, 4'sd0,  1'b0, 1'b0};
        rows[9]  = '{OP_XOR,   FN3_W,  32'h0,         32'h0,         -4'sd2, 1'b0, 1'b1};
        rows[10] = '{OP_PASS,  FN3_W,  32'h1111_1111, 32'hdead_beef, 4'sd0,  1'b0, 1'b0};
        rows[11] = '{OP_PASS,  FN3_W,  32'h2222_2222, 32'h0000_0042, -4'sd2, 1'b0, 1'b0};
        rows[12] = '{OP_STORE, FN3_W,  32'h10,        32'h8081_8283, 4'sd0,  1'b0, 1'b0};
        rows[13] = '{OP_STORE, FN3_W,  32'h14,        32'h7f00_ff01, 4'sd1,  1'b0, 1'b0};
        rows[14] = '{OP_STORE, FN3_H,  32'h16,        32'hbeef_9abc, 4'sd0,  1'b0, 1'b0};
        rows[15] = '{OP_STORE, FN3_B,  32'h11,        32'h1234_5655, 4'sd0,  1'b0, 1'b0};
        rows[16] = '{OP_LOAD,  FN3_W,  32'h10,        32'h0bad_0bad, 4'sd0,  1'b0, 1'b0};
        rows[17] = '{OP_LOAD,  FN3_B,  32'h10,        32'h0bad_0bad, 4'sd0,  1'b0, 1'b0};
        rows[18] = '{OP_LOAD,  FN3_BU, 32'h10,        32'h0bad_0bad, 4'sd0,  1'b0, 1'b0};
        rows[19] = '{OP_LOAD,  FN3_B,  32'h11,        32'h0bad_0bad, 4'sd0,  1'b0, 1'b0};
        rows[20] = '{OP_LOAD,  FN3_H,  32'h12,        32'h0bad_0bad, 4'sd0,  1'b0, 1'b0};
        rows[21] = '{OP_LOAD,  FN3_HU, 32'h12,        32'h0bad_0bad, 4'sd0,  1'b0, 1'b0};
        rows[22] = '{OP_LOAD,  FN3_H,  32'h16,        32'h0bad_0bad, 4'sd0,  1'b0, 1'b0};
        rows[23] = '{OP_LOAD,  FN3_HU, 32'h14,        32'h0bad_0bad, 4'sd0,  1'b0, 1'b0};
        rows[24] = '{OP_LOAD,  FN3_W,  32'h10,        32'h0,         4'sd0,  1'b1, 1'b0};
        rows[25] = '{OP_LOAD,  FN3_W,  32'h14,        32'h0,         4'sd0,  1'b1, 1'b0};
        rows[26] = '{OP_LOAD,  FN3_W,  32'h110,       32'h0,         4'sd0,  1'b1, 1'b0};
        rows[27] = '{OP_LOAD,  FN3_W,  32'h14,        32'h0,         4'sd0,  1'b1, 1'b0};
        rows[28] = '{OP_LOAD,  FN3_W,  32'h10,        32'h0,         4'sd0,  1'b1, 1'b0};
        rows[29] = '{OP_LOAD,  FN3_W,  32'h114,       32'h0,         4'sd0,  1'b1, 1'b0};
        rows[30] = '{OP_STORE, FN3_W,  32'h30,        32'h1357_9bdf, 4'sd0,  1'b0, 1'b0};
        rows[31] = '{OP_LOAD,  FN3_W,  32'h30,        32'h0,         4'sd0,  1'b1, 1'b0};
        rows[32] = '{OP_LOAD,  FN3_W,  32'h30,        32'h0,         4'sd0,  1'b1, 1'b0};
        rows[33] = '{OP_LOAD,  FN3_W,  32'h30,        32'h0,         4'sd0,  1'b1, 1'b0};
        rows[34] = '{OP_LOAD,  FN3_W,  32'h30,        32'h0,         4'sd0,  1'b1, 1'b0};
        rows[35] = '{OP_LOAD,  FN3_W,  32'h30,        32'h0,         4'sd0,  1'b0, 1'b0};
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    // Schedules one group of rows on both inputs and queues the expected results.
    task automatic run_group(input int first, input int last);
        logic [`GRID_XLEN-1:0] val1 [SPAN];
        logic [`GRID_XLEN-1:0] val2 [SPAN];
        logic                  en1 [SPAN];
        logic                  en2 [SPAN];
        logic [`GRID_XLEN-1:0] a;
        logic [`GRID_XLEN-1:0] b;
        int                    t1, t2, next1, next2, span, base;
        for (int s = 0; s < SPAN; s++) begin
            en1[s] = 1'b0;
            en2[s] = 1'b0;
        end
        next1    = 0;
        next2    = 0;
        span     = 0;
        base     = cycle;
        saw_full = 1'b0;
        for (int r = first; r <= last; r++) begin
            a = rows[r].a;
            b = rows[r].b;
            if (rows[r].rnd) begin
                a = $random(seed);
                b = $random(seed);
            end
            t1 = next1;
            t2 = t1 + int'(rows[r].delay);
            if (t2 < next2) begin    // Keep each input in order.
                t1 = t1 + (next2 - t2);
                t2 = next2;
            end
            next1   = t1 + 1;
            next2   = t2 + 1;
            en1[t1] = 1'b1;
            val1[t1] = a;
            en2[t2] = 1'b1;
            val2[t2] = b;
            span = (next1 > next2) ? next1 : next2;
            case (rows[r].op)
                OP_STORE: model_store(a, b, rows[r].fn3);
                OP_LOAD:  expect_result(model_load(a, rows[r].fn3), -1, OP_LOAD);
                OP_PASS:  expect_result(alu_expect(OP_PASS, a, b), base + t2 + 2, OP_PASS);
                default:  expect_result(alu_expect(rows[r].op, a, b),
                                        base + ((t1 > t2) ? t1 : t2) + 2, rows[r].op);
            endcase
        end
        op        = rows[first].op;
        fn3       = rows[first].fn3;
        mem_stall = rows[first].stall;
        for (int s = 0; s < span; s++) begin
            data_valid_in1 = en1[s];
            data_in1       = en1[s] ? val1[s] : '0;
            data_valid_in2 = en2[s];
            data_in2       = en2[s] ? val2[s] : '0;
            next_cycle();
        end
        data_valid_in1 = 1'b0;
        data_valid_in2 = 1'b0;
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while (exp_val_q.size() != 0) begin
            if (n == DRAIN_LIMIT) begin
                $display("Timeout: %0d results still outstanding after %0d cycles",
                         exp_val_q.size(), n);
                $display("Simulation failed");
                $finish;
            end
            next_cycle();
            n++;
        end
        repeat (4) next_cycle();    // A last store reaches memory.
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Output monitor
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always @(negedge clk) begin
        if (grid_slot_top_inst.lsq_full)
            saw_full = 1'b1;
        if (reset) begin
            check_flag(data_valid_out, 1'b0, "data_valid_out during reset");
        end else if (data_valid_out) begin
            if (mem_stall) begin
                errors++;
                $display("ERR %0t: result while the memory is stalled", $time);
            end
            if (exp_val_q.size() == 0) begin
                errors++;
                $display("ERR %0t: unexpected result %h", $time, data_out);
            end else begin
                mon_val = exp_val_q.pop_front();
                mon_cyc = exp_cyc_q.pop_front();
                mon_op  = exp_op_q.pop_front();
                check_result(data_out, mon_val, mon_op);
                if (mon_cyc >= 0)
                    check_latency(cycle, mon_cyc, mon_op);
                nresults++;
            end
        end
    end

    initial begin
        int first;
        seed           = 32'ha098;
        reset          = 1'b1;
        op             = OP_ADD;
        fn3            = FN3_W;
        data_in1       = '0;
        data_in2       = '0;
        data_valid_in1 = 1'b0;
        data_valid_in2 = 1'b0;
        mem_stall      = 1'b0;
        fill_table();
        repeat (10) @(posedge clk);
        #1;
        reset = 1'b0;
        check_flag(grid_slot_top_inst.lsq_full, 1'b0, "lsq_full after reset");
        first = 0;
        // A group ends where op, fn3 or the stall setting changes.
        for (int i = 0; i < NUM_ROWS; i++) begin
            if (i == NUM_ROWS - 1 || rows[i+1].op != rows[i].op ||
                rows[i+1].fn3 != rows[i].fn3 || rows[i+1].stall != rows[i].stall) begin
                run_group(first, i);
                if (first == RESET_FIRST) begin
                    repeat (4) next_cycle();
                    check_flag(saw_full, 1'b1, "lsq_full before reset");
                    reset = 1'b1;                 // Flushes the stalled loads.
                    repeat (10) next_cycle();
                    exp_val_q.delete();
                    exp_cyc_q.delete();
                    exp_op_q.delete();
                    reset     = 1'b0;
                    mem_stall = 1'b0;
                    next_cycle();
                    check_flag(grid_slot_top_inst.lsq_full, 1'b0, "lsq_full after reset");
                end else if (rows[i].stall) begin
                    repeat (12) next_cycle();
                    check_flag(saw_full, 1'b1, "lsq_full under stall");
                    mem_stall = 1'b0;
                end
                wait_drain();
                first = i + 1;
            end
        end
        repeat (8) next_cycle();    // Stray results show up here.
        $display("Results checked: %0d, errors: %0d", nresults, errors);
        if (errors == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- files.f
+incdir+.
grid_pkg.sv
operand_fifo.sv
slot_op_unit.sv
grid_pr_slot.sv
lsq_memory.sv
grid_slot_top.sv
tb_clock_gen.sv
grid_slot_tb.sv
